// ==== logic/wb_pkg.sv ====
// Wishbone bus definitions shared by the safety bridge.
// Widths of the pipelined bus and the request and response bundles.

package wb_pkg;

	// Word address width, matching a 32-bit data bus with byte selects
	localparam int unsigned ADDR_W = 28;
	localparam int unsigned DATA_W = 32;
	localparam int unsigned SEL_W  = DATA_W / 8;

	////////////////////////////////////////////////////////////////////////////
	//
	// Request bundle
	//
	////////////////////////////////////////////////////////////////////////////

	// Everything that travels with stb, 65 bits in all
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [SEL_W-1:0]  sel;
	} wb_req_t;

	////////////////////////////////////////////////////////////////////////////
	//
	// Response bundle
	//
	////////////////////////////////////////////////////////////////////////////

	// A well behaved slave never raises ack and err in the same cycle
	typedef struct packed {
		logic              ack;
		logic              err;
		logic [DATA_W-1:0] data;
	} wb_rsp_t;

endpackage

// ==== logic/safety_pkg.sv ====
// Safety bridge policy.
// Timeout limit, tracker width, self-reset option and fault causes.

package safety_pkg;

	// Longest run of downstream stall, or of waiting on a return
	localparam int unsigned TIMEOUT_CYCLES = 12;

	// Outstanding counter and timers, wide enough for TIMEOUT_CYCLES
	localparam int unsigned TRACK_W = 4;

	// Registered self reset of the slave, also raised on a fault
	localparam bit OPT_SELF_RESET = 1'b1;

	// Why the bridge last cut the slave off
	typedef enum logic [1:0] {
		NONE,
		TIMEOUT,
		BAD_RETURN,
		DOUBLE_RESPONSE
	} fault_cause_t;

endpackage

// ==== logic/wb_skid_buffer.sv ====
// Wishbone request skid buffer.
// Holds one extra request so that the upstream stall comes from a register.

`timescale 1ns/1ns

module wb_skid_buffer
(
	input  logic            i_clk,
	input  logic            i_reset,
	input  logic            i_wb_cyc,
	input  logic            i_valid,
	input  wb_pkg::wb_req_t i_req,
	output logic            o_stall,
	output logic            o_valid,
	output wb_pkg::wb_req_t o_req,
	input  logic            i_ready
);

	logic            r_valid;
	wb_pkg::wb_req_t r_req;

	// The held entry is the only thing that can stall the master
	assign o_stall = r_valid;
	assign o_valid = i_wb_cyc && (r_valid || i_valid);
	assign o_req   = r_valid ? r_req : i_req;

	// Capture an incoming request when the consumer refuses the current one
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			r_valid <= 1'b0;
		else if (i_valid && !o_stall && o_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (!o_stall)
			r_req <= i_req;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Checks
	//
	////////////////////////////////////////////////////////////////////////////

	// A held request must not change while it waits for the forward stage
	a_held_stable : assert property (
		@(posedge i_clk) disable iff (i_reset)
		(o_valid && !i_ready) |=> (!i_wb_cyc || (o_valid && $stable(o_req)))
	);

endmodule

// ==== logic/wb_return_tracker.sv ====
// Return tracker for the Wishbone safety bridge.
// Counts owed returns, times stall and wait, raises faults and self reset.

`timescale 1ns/1ns

module wb_return_tracker
(
	input  logic                               i_clk,
	input  logic                               i_reset,
	input  logic                               i_wb_cyc,
	input  logic                               i_accept,
	input  logic                               i_dn_cyc,
	input  logic                               i_dn_stb,
	input  logic                               i_dn_stall,
	input  wb_pkg::wb_rsp_t                    i_dn_rsp,
	input  wb_pkg::wb_rsp_t                    i_up_rsp,
	output logic [safety_pkg::TRACK_W-1:0]     o_outstanding,
	output logic                               o_timeout,
	output logic                               o_fault,
	output logic                               o_reset,
	output safety_pkg::fault_cause_t           o_fault_cause
);

	logic [safety_pkg::TRACK_W-1:0] stall_timer;
	logic [safety_pkg::TRACK_W-1:0] wait_timer;
	logic [safety_pkg::TRACK_W-1:0] in_flight;
	logic                           dn_ret;
	logic                           stall_run;
	logic                           wait_run;
	logic                           bad_return;
	logic                           double_rsp;
	logic                           fault_event;

	assign dn_ret    = i_dn_cyc && (i_dn_rsp.ack || i_dn_rsp.err);
	assign stall_run = i_dn_stb && i_dn_stall;
	assign wait_run  = i_dn_cyc && !dn_ret && (o_outstanding != '0);

	// A stalled request and a registered upstream return cannot be answered now
	assign in_flight = {{(safety_pkg::TRACK_W-1){1'b0}}, stall_run}
		+ {{(safety_pkg::TRACK_W-1){1'b0}}, i_up_rsp.ack || i_up_rsp.err};

	assign bad_return  = i_wb_cyc && dn_ret && (o_outstanding <= in_flight);
	assign double_rsp  = i_wb_cyc && i_dn_cyc && i_dn_rsp.ack && i_dn_rsp.err;
	assign fault_event = bad_return || double_rsp || (i_wb_cyc && o_timeout);

	// An upstream err ends the whole bus cycle, so nothing stays owed after it
	always_ff @(posedge i_clk)
	begin
		if (i_reset || o_reset || i_up_rsp.err || !i_wb_cyc)
			o_outstanding <= '0;
		else
			case ({i_accept, i_up_rsp.ack})
				2'b10: o_outstanding <= o_outstanding + 1'b1;
				2'b01: o_outstanding <= o_outstanding - 1'b1;
				default: o_outstanding <= o_outstanding;
			endcase
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Stall and wait timers
	//
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !stall_run)
			stall_timer <= '0;
		else if (32'(stall_timer) < safety_pkg::TIMEOUT_CYCLES)
			stall_timer <= stall_timer + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !wait_run)
			wait_timer <= '0;
		else if (32'(wait_timer) < safety_pkg::TIMEOUT_CYCLES)
			wait_timer <= wait_timer + 1'b1;
	end

	// Timers count earlier cycles, so this fires on the last allowed cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_timeout <= 1'b0;
		else
			o_timeout <= (stall_run
					&& 32'(stall_timer) >= safety_pkg::TIMEOUT_CYCLES - 1)
				|| (wait_run
					&& 32'(wait_timer) >= safety_pkg::TIMEOUT_CYCLES - 1);
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Fault and self reset
	//
	////////////////////////////////////////////////////////////////////////////

	// The fault holds until the master has let go of the bus
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_fault <= 1'b0;
		else if (!i_wb_cyc && (o_reset || !safety_pkg::OPT_SELF_RESET))
			o_fault <= 1'b0;
		else if (fault_event)
			o_fault <= 1'b1;
	end

	// Keep the first cause of a fault visible until the next one
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_fault_cause <= safety_pkg::NONE;
		else if (fault_event && !o_fault)
		begin
			if (double_rsp)
				o_fault_cause <= safety_pkg::DOUBLE_RESPONSE;
			else if (bad_return)
				o_fault_cause <= safety_pkg::BAD_RETURN;
			else
				o_fault_cause <= safety_pkg::TIMEOUT;
		end
	end

	generate
		if (safety_pkg::OPT_SELF_RESET)
		begin : g_self_reset
			always_ff @(posedge i_clk)
			begin
				o_reset <= i_reset || o_fault || fault_event;
			end

			// The slave is held in reset for as long as the fault stands
			a_fault_resets : assert property (
				@(posedge i_clk) disable iff (i_reset)
				o_fault |-> o_reset
			);
		end
		else
		begin : g_pass_reset
			assign o_reset = i_reset;
		end
	endgenerate

	// Upstream acks come from the forward stage and must match owed returns
	a_no_underflow : assert property (
		@(posedge i_clk) disable iff (i_reset)
		(i_wb_cyc && i_up_rsp.ack) |-> (o_outstanding != '0)
	);

endmodule

// ==== logic/wb_forward_stage.sv ====
// Forwarding stage of the Wishbone safety bridge.
// Registers requests toward the slave and returns toward the master.

`timescale 1ns/1ns

module wb_forward_stage
(
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic                           i_wb_cyc,
	input  logic                           i_valid,
	input  wb_pkg::wb_req_t                i_req,
	output logic                           o_ready,
	input  logic                           i_fault,
	input  logic                           i_self_reset,
	input  logic                           i_timeout,
	input  logic [safety_pkg::TRACK_W-1:0] i_outstanding,
	output logic                           o_dn_cyc,
	output logic                           o_dn_stb,
	output wb_pkg::wb_req_t                o_dn_req,
	input  logic                           i_dn_stall,
	input  wb_pkg::wb_rsp_t                i_dn_rsp,
	output wb_pkg::wb_rsp_t                o_up_rsp
);

	logic                           up_ack;
	logic                           up_err;
	logic [wb_pkg::DATA_W-1:0]      up_data;
	logic                           held;
	logic                           pending_up;
	logic                           dn_ack;
	logic                           dn_err;
	logic                           bad_return;
	logic                           owed;
	logic [safety_pkg::TRACK_W-1:0] in_flight;
	logic                           drop;

	assign held       = o_dn_stb && i_dn_stall;
	assign pending_up = up_ack || up_err;
	assign dn_ack     = o_dn_cyc && i_dn_rsp.ack;
	assign dn_err     = o_dn_cyc && i_dn_rsp.err;

	// Returns owed upstream, and those the slave may still legally send
	assign in_flight  = {{(safety_pkg::TRACK_W-1){1'b0}}, held}
		+ {{(safety_pkg::TRACK_W-1){1'b0}}, pending_up};
	assign owed       = i_outstanding > {{(safety_pkg::TRACK_W-1){1'b0}}, pending_up};
	assign bad_return = (dn_ack || dn_err) && (i_outstanding <= in_flight);

	// On a fault every queued request is taken and answered with err
	always_comb
	begin
		o_ready = !held;
		if (i_reset)
			o_ready = 1'b0;
		if (i_fault)
			o_ready = 1'b1;
		else if (i_self_reset)
			o_ready = 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Downstream request
	//
	////////////////////////////////////////////////////////////////////////////

	assign drop = i_reset || i_fault || i_self_reset || i_timeout || dn_err || up_err;

	always_ff @(posedge i_clk)
	begin
		if (drop)
			o_dn_cyc <= 1'b0;
		else
			o_dn_cyc <= i_wb_cyc && (o_dn_cyc || i_valid);
	end

	always_ff @(posedge i_clk)
	begin
		if (drop || !i_wb_cyc)
			o_dn_stb <= 1'b0;
		else if (!held)
			o_dn_stb <= i_valid;
	end

	always_ff @(posedge i_clk)
	begin
		if (!held)
			o_dn_req <= i_req;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Upstream return
	//
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
		begin
			up_ack <= 1'b0;
			up_err <= 1'b0;
		end
		else if (i_fault)
		begin
			up_ack <= 1'b0;
			up_err <= i_valid && o_ready;
		end
		else if (i_self_reset || up_err)
		begin
			up_ack <= 1'b0;
			up_err <= 1'b0;
		end
		else if (i_timeout || dn_err || bad_return)
		begin
			up_ack <= 1'b0;
			up_err <= owed;
		end
		else
		begin
			up_ack <= dn_ack;
			up_err <= 1'b0;
		end
	end

	always_ff @(posedge i_clk)
	begin
		up_data <= i_dn_rsp.data;
	end

	assign o_up_rsp = '{ack: up_ack, err: up_err, data: up_data};

	a_one_response : assert property (
		@(posedge i_clk) disable iff (i_reset)
		!(o_up_rsp.ack && o_up_rsp.err)
	);

endmodule

// ==== logic/wb_safety_top.sv ====
// Wishbone safety bridge between a pipelined master and an untrusted slave.
// Faults on timeout or bad returns, ends the cycle with err, resets the slave.

`timescale 1ns/1ns

module wb_safety_top
(
	input  logic                     i_clk,
	input  logic                     i_reset,
	// Upstream master
	input  logic                     i_wb_cyc,
	input  logic                     i_wb_stb,
	input  wb_pkg::wb_req_t          i_wb_req,
	output logic                     o_wb_stall,
	output wb_pkg::wb_rsp_t          o_wb_rsp,
	// Downstream slave
	output logic                     o_dn_cyc,
	output logic                     o_dn_stb,
	output wb_pkg::wb_req_t          o_dn_req,
	input  logic                     i_dn_stall,
	input  wb_pkg::wb_rsp_t          i_dn_rsp,
	// Safety status
	output logic                     o_reset,
	output logic                     o_fault,
	output safety_pkg::fault_cause_t o_fault_cause
);

	logic                           skd_valid;
	logic                           skd_ready;
	wb_pkg::wb_req_t                skd_req;
	logic [safety_pkg::TRACK_W-1:0] outstanding;
	logic                           timeout;

	wb_skid_buffer u_skid (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc),
		.i_valid(i_wb_stb), .i_req(i_wb_req), .o_stall(o_wb_stall),
		.o_valid(skd_valid), .o_req(skd_req), .i_ready(skd_ready)
	);

	wb_return_tracker u_tracker (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc),
		.i_accept(skd_valid && skd_ready),
		.i_dn_cyc(o_dn_cyc), .i_dn_stb(o_dn_stb), .i_dn_stall(i_dn_stall),
		.i_dn_rsp(i_dn_rsp), .i_up_rsp(o_wb_rsp), .o_outstanding(outstanding),
		.o_timeout(timeout), .o_fault(o_fault), .o_reset(o_reset),
		.o_fault_cause(o_fault_cause)
	);

	wb_forward_stage u_forward (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc),
		.i_valid(skd_valid), .i_req(skd_req), .o_ready(skd_ready),
		.i_fault(o_fault), .i_self_reset(o_reset), .i_timeout(timeout),
		.i_outstanding(outstanding), .o_dn_cyc(o_dn_cyc), .o_dn_stb(o_dn_stb),
		.o_dn_req(o_dn_req), .i_dn_stall(i_dn_stall), .i_dn_rsp(i_dn_rsp),
		.o_up_rsp(o_wb_rsp)
	);

endmodule

// ==== tests/tb_wb_safety.sv ====
// Testbench for the Wishbone safety bridge.
// Drives the upstream master, models the downstream slave, checks with assertions.

`timescale 1ns/1ns

module tb_wb_safety;

	logic                     i_clk;
	logic                     i_reset;
	logic                     i_wb_cyc;
	logic                     i_wb_stb;
	wb_pkg::wb_req_t          i_wb_req;
	logic                     o_wb_stall;
	wb_pkg::wb_rsp_t          o_wb_rsp;
	logic                     o_dn_cyc;
	logic                     o_dn_stb;
	wb_pkg::wb_req_t          o_dn_req;
	logic                     i_dn_stall;
	wb_pkg::wb_rsp_t          i_dn_rsp;
	logic                     o_reset;
	logic                     o_fault;
	safety_pkg::fault_cause_t o_fault_cause;

	// Test control and bookkeeping
	int              fails = 0;
	int              tests = 0;
	int              acks;
	int              errs;
	int              dn_owed = 0;
	int              wait_cnt = 0;
	int              stall_left = 0;
	bit              strict = 0;
	bit              no_fault = 0;
	bit              err_mode = 0;
	bit              double_mode = 0;
	bit              spurious = 0;
	bit              reset_seen;
	bit              stall_seen;
	wb_pkg::wb_req_t up_q[$];
	wb_pkg::wb_req_t exp_req;
	wb_pkg::wb_req_t prev_wb_req;
	logic [31:0]     prev_dn_data;
	safety_pkg::fault_cause_t expect_cause = safety_pkg::NONE;

	wb_safety_top i_dut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever
			#50 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Checks
	//
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		prev_wb_req  <= i_wb_req;
		prev_dn_data <= i_dn_rsp.data;
	end

	// A request taken with the skid buffer empty reaches the slave one edge later
	a_pass : assert property (@(posedge i_clk) disable iff (i_reset)
		(strict && i_wb_cyc && i_wb_stb && !o_wb_stall && !(o_dn_stb && i_dn_stall))
		|=> (o_dn_stb && o_dn_req == prev_wb_req))
	else
	begin
		fails++;
		$display("[ERROR] %0t o_dn_req got %h expected %h", $time, o_dn_req, prev_wb_req);
	end

	a_ack : assert property (@(posedge i_clk) disable iff (i_reset)
		(strict && i_wb_cyc && o_dn_cyc && i_dn_rsp.ack)
		|=> (o_wb_rsp.ack && o_wb_rsp.data == prev_dn_data))
	else
	begin
		fails++;
		$display("[ERROR] %0t o_wb_rsp got %h expected ack with data %h",
			$time, o_wb_rsp, prev_dn_data);
	end

	a_dn_err : assert property (@(posedge i_clk) disable iff (i_reset)
		(err_mode && i_wb_cyc && o_dn_cyc && i_dn_rsp.err)
		|=> (o_wb_rsp.err && !o_dn_cyc))
	else
	begin
		fails++;
		$display("[ERROR] %0t o_wb_rsp.err got %b expected 1, o_dn_cyc got %b expected 0",
			$time, o_wb_rsp.err, o_dn_cyc);
	end

	a_timeout : assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wb_cyc && $rose(i_dut.timeout)) |=> (o_fault && o_reset && !o_dn_cyc))
	else
	begin
		fails++;
		$display("%0t timeout did not raise fault and self reset and drop o_dn_cyc", $time);
	end

	a_no_fault : assert property (@(posedge i_clk) disable iff (i_reset)
		no_fault |-> !o_fault)
	else
	begin
		fails++;
		$display("[ERROR] %0t o_fault got %b expected 0", $time, o_fault);
	end

	a_cause : assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(o_fault) |-> (o_fault_cause == expect_cause && o_reset))
	else
	begin
		fails++;
		$display("[ERROR] %0t o_fault_cause got %s expected %s",
			$time, o_fault_cause.name(), expect_cause.name());
	end

	// Everything here is sampled at the falling edge, where all outputs are settled
	always @(negedge i_clk)
	begin
		if (o_wb_rsp.ack)
			acks++;
		if (o_wb_rsp.err)
			errs++;
		if (o_reset)
			reset_seen = 1'b1;
		if (o_wb_stall)
			stall_seen = 1'b1;
		if (!i_reset && o_dn_cyc && o_dn_stb && !i_dn_stall)
		begin
			dn_owed++;
			if (strict)
			begin
				exp_req = (up_q.size() > 0) ? up_q.pop_front() : 'x;
				assert (o_dn_req == exp_req)
				else
				begin
					fails++;
					$display("[ERROR] %0t o_dn_req got %h expected %h", $time, o_dn_req, exp_req);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Downstream slave model
	//
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		i_dn_stall = 1'b0;
		i_dn_rsp   = '0;
		forever
		begin
			@(posedge i_clk);
			#5;
			i_dn_rsp = '0;
			if (o_reset || !o_dn_cyc)
			begin
				dn_owed  = 0;
				wait_cnt = 0;
			end
			i_dn_stall = (stall_left > 0);
			if (stall_left > 0)
				stall_left--;
			if (spurious)
			begin
				i_dn_rsp.ack = 1'b1;
				spurious = 1'b0;
			end
			else if (dn_owed > 0 && wait_cnt == 0)
				wait_cnt = $urandom_range(1, 4);
			else if (wait_cnt == 1)
			begin
				i_dn_rsp.ack  = !err_mode;
				i_dn_rsp.err  = err_mode || double_mode;
				i_dn_rsp.data = $urandom;
				dn_owed--;
				wait_cnt = 0;
			end
			else if (wait_cnt > 1)
				wait_cnt--;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Upstream master
	//
	////////////////////////////////////////////////////////////////////////////

	function automatic wb_pkg::wb_req_t rand_req();
		wb_pkg::wb_req_t r;
		logic [31:0]     word;
		word   = $urandom;
		r.we   = word[0];
		word   = $urandom;
		r.addr = word[wb_pkg::ADDR_W-1:0];
		r.data = $urandom;
		word   = $urandom;
		r.sel  = word[wb_pkg::SEL_W-1:0];
		return r;
	endfunction

	task automatic step(input int n);
		repeat (n)
		begin
			@(posedge i_clk);
			#5;
		end
	endtask

	task automatic run_burst(input int n, input bit keep_cyc);
		int sent;
		int waited;
		bit took;
		sent     = 0;
		waited   = 0;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_req = rand_req();
		while (sent < n && errs == 0 && waited < 200)
		begin
			@(negedge i_clk);
			took = i_wb_stb && !o_wb_stall;
			if (took)
			begin
				up_q.push_back(i_wb_req);
				sent++;
			end
			step(1);
			waited++;
			if (took && sent < n)
				i_wb_req = rand_req();
			else if (took)
				i_wb_stb = 1'b0;
		end
		i_wb_stb = 1'b0;
		while (acks + errs < sent && errs == 0 && waited < 200)
		begin
			step(1);
			waited++;
		end
		if (!keep_cyc)
			i_wb_cyc = 1'b0;
	endtask

	task automatic start_test();
		up_q.delete();
		acks        = 0;
		errs        = 0;
		stall_left  = 0;
		reset_seen  = 1'b0;
		stall_seen  = 1'b0;
		strict      = 1'b0;
		no_fault    = 1'b0;
		err_mode    = 1'b0;
		double_mode = 1'b0;
	endtask

	task automatic end_test(input string name);
		step(4);
		tests++;
		$display("test %0d %s finished, failed checks so far %0d", tests, name, fails);
	endtask

	initial
	begin
		#((6 * 230 + 100) * 100);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h8141));
		i_reset  = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_req = '0;
		step(5);
		i_reset = 1'b0;
		step(3);

		start_test();
		strict   = 1'b1;
		no_fault = 1'b1;
		run_burst(8, 1'b0);
		assert (acks == 8)
		else
		begin
			fails++;
			$display("[ERROR] %0t upstream ack count got %0d expected %0d", $time, acks, 8);
		end
		end_test("pass-through");

		start_test();
		strict     = 1'b1;
		no_fault   = 1'b1;
		stall_left = 6;
		run_burst(6, 1'b0);
		assert (stall_seen && acks == 6 && up_q.size() == 0)
		else
		begin
			fails++;
			$display("%0t back-pressure lost, repeated or never stalled a request", $time);
		end
		end_test("back-pressure");

		start_test();
		expect_cause = safety_pkg::TIMEOUT;
		stall_left   = 30;
		run_burst(2, 1'b0);
		assert (errs > 0 && reset_seen)
		else
		begin
			fails++;
			$display("%0t stall timeout gave no upstream err or no self reset", $time);
		end
		end_test("timeout");

		start_test();
		expect_cause = safety_pkg::BAD_RETURN;
		run_burst(1, 1'b1);
		reset_seen = 1'b0;
		spurious   = 1'b1;
		step(3);
		i_wb_cyc = 1'b0;
		step(3);
		assert (reset_seen && !o_fault)
		else
		begin
			fails++;
			$display("%0t unexpected ack gave no self reset or the fault did not clear", $time);
		end
		end_test("unexpected return");

		start_test();
		expect_cause = safety_pkg::DOUBLE_RESPONSE;
		double_mode  = 1'b1;
		run_burst(1, 1'b0);
		assert (errs > 0)
		else
		begin
			fails++;
			$display("%0t double response was not answered upstream with err", $time);
		end
		end_test("double response");

		start_test();
		no_fault = 1'b1;
		err_mode = 1'b1;
		run_burst(1, 1'b0);
		assert (errs == 1)
		else
		begin
			fails++;
			$display("[ERROR] %0t upstream err count got %0d expected %0d", $time, errs, 1);
		end
		end_test("downstream error");

		$display("tests run %0d, failed checks %0d", tests, fails);
		if (fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
logic/wb_pkg.sv
logic/safety_pkg.sv
logic/wb_skid_buffer.sv
logic/wb_return_tracker.sv
logic/wb_forward_stage.sv
logic/wb_safety_top.sv
tests/tb_wb_safety.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_wb_safety
RTL_TOP   := wb_safety_top
FILELIST  := list.f
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) \
		logic/wb_pkg.sv logic/safety_pkg.sv logic/wb_skid_buffer.sv \
		logic/wb_return_tracker.sv logic/wb_forward_stage.sv logic/wb_safety_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
